/* Makefile */
TOP   := tb_soc_peripherals
BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
	  --top-module $(TOP) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: PASS" $(LOG); then \
	  echo "Result: test passed"; \
	else \
	  echo "Result: test failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

/* files.f */
+incdir+logic
logic/soc_periph_pkg.sv
logic/soc_apb_bridge.sv
logic/soc_ctrl_regs.sv
logic/apb_stdout.sv
logic/soc_peripherals.sv
sim/tb_soc_peripherals.sv

/* logic/apb_stdout.sv */
// APB character output
`timescale 1ns/10ps
`include "soc_periph_defs.svh"

module apb_stdout (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  soc_periph_pkg::apb_req_t    apb_i,
  input  logic                        psel_i,
  output soc_periph_pkg::apb_rsp_t    apb_rsp_o,
  output logic                        stdout_valid_o,
  output soc_periph_pkg::stdout_evt_t stdout_o
);

  localparam int unsigned word_lsb   = $clog2(`SOC_STRB_WIDTH);
  localparam int unsigned win_msb    = $clog2(`SOC_WINDOW_SIZE) - 1;
  localparam int unsigned idx_width  = win_msb - word_lsb + 1;
  localparam int unsigned core_width = $clog2(`SOC_N_CORES);

  logic [idx_width-1:0]        word_idx;
  logic [core_width-1:0]       core;
  logic                        core_ok;
  logic                        wr_en;
  logic [`SOC_COUNT_WIDTH-1:0] count_q [`SOC_N_CORES];
  logic                        evt_valid_q;
  soc_periph_pkg::stdout_evt_t evt_q;

  // Each core owns one word in the window
  assign word_idx = apb_i.paddr[win_msb:word_lsb];
  assign core_ok  = (word_idx < idx_width'(`SOC_N_CORES));
  assign core     = word_idx[core_width-1:0];
  assign wr_en    = psel_i && apb_i.penable && apb_i.pwrite && core_ok;

  always_comb begin
    apb_rsp_o         = '0;
    apb_rsp_o.pready  = psel_i && apb_i.penable;
    apb_rsp_o.pslverr = psel_i && !core_ok;
    if (core_ok) begin
      apb_rsp_o.prdata = `SOC_DATA_WIDTH'(count_q[core]);
    end
  end

  // Per-core character counters, wrapping at 16 bits
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `SOC_N_CORES; i++) begin
        count_q[i] <= '0;
      end
    end else if (wr_en) begin
      count_q[core] <= count_q[core] + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      evt_valid_q <= 1'b0;
    end else begin
      evt_valid_q <= wr_en;
    end
  end

  // Event payload, meaningful only alongside the valid pulse
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      evt_q.core <= core;
      evt_q.chr  <= apb_i.pwdata[7:0];
    end
  end

  assign stdout_valid_o = evt_valid_q;
  assign stdout_o       = evt_q;

  // Every strobe traces back to a write access that came right after its own setup phase
  a_evt_from_write: assert property (@(posedge clk_i) disable iff (reset_i)
    stdout_valid_o |-> $past(psel_i && apb_i.penable && apb_i.pwrite) &&
                       $past(psel_i && !apb_i.penable, 2) &&
                       ($past(apb_i.paddr, 2) == $past(apb_i.paddr)));

endmodule

/* logic/soc_apb_bridge.sv */
// Host to APB bridge
`timescale 1ns/10ps
`include "soc_periph_defs.svh"

module soc_apb_bridge (
  input  logic                                             clk_i,
  input  logic                                             reset_i,
  input  logic                                             req_valid_i,
  input  soc_periph_pkg::host_req_t                        req_i,
  output logic                                             req_ready_o,
  output logic                                             rsp_valid_o,
  output soc_periph_pkg::host_rsp_t                        rsp_o,
  output soc_periph_pkg::apb_req_t                         apb_o,
  output logic [`SOC_N_APB_SLAVES-1:0]                     apb_sel_o,
  input  soc_periph_pkg::apb_rsp_t [`SOC_N_APB_SLAVES-1:0] apb_rsp_i
);

  localparam int unsigned n_slaves = `SOC_N_APB_SLAVES;

  // Slave 0 is the control block, slave 1 is stdout
  localparam logic [n_slaves-1:0][`SOC_ADDR_WIDTH-1:0] win_base = {
    `SOC_PERIPH_BASE + `SOC_STDOUT_OFFSET,
    `SOC_PERIPH_BASE + `SOC_CTRL_OFFSET
  };

  soc_periph_pkg::bridge_state_e state_q;
  soc_periph_pkg::bridge_state_e state_d;
  soc_periph_pkg::host_req_t     req_q;
  soc_periph_pkg::host_rsp_t     rsp_q;
  soc_periph_pkg::apb_rsp_t      sel_rsp;
  logic [n_slaves-1:0]           dec_sel;
  logic [n_slaves-1:0]           sel_q;
  logic                          accept;

  assign req_ready_o = (state_q == soc_periph_pkg::st_idle);
  assign accept      = req_valid_i && req_ready_o;

  // Window decode of the incoming address, a miss leaves all bits low
  always_comb begin
    dec_sel = '0;
    for (int i = 0; i < n_slaves; i++) begin
      dec_sel[i] = (req_i.addr >= win_base[i]) &&
                   (req_i.addr < win_base[i] + `SOC_WINDOW_SIZE);
    end
  end

  // Response of whichever slave is currently selected
  always_comb begin
    sel_rsp = '0;
    for (int i = 0; i < n_slaves; i++) begin
      if (sel_q[i]) begin
        sel_rsp = apb_rsp_i[i];
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      soc_periph_pkg::st_idle: begin
        if (accept) begin
          // Misses skip the APB transfer entirely
          state_d = (dec_sel != '0) ? soc_periph_pkg::st_setup : soc_periph_pkg::st_respond;
        end
      end
      soc_periph_pkg::st_setup:  state_d = soc_periph_pkg::st_access;
      soc_periph_pkg::st_access: begin
        if (sel_rsp.pready) begin
          state_d = soc_periph_pkg::st_respond;
        end
      end
      soc_periph_pkg::st_respond: state_d = soc_periph_pkg::st_idle;
      default: state_d = soc_periph_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= soc_periph_pkg::st_idle;
      sel_q   <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        sel_q <= dec_sel;
      end
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
    if (state_q == soc_periph_pkg::st_idle) begin
      // Preloaded as a decode error, overwritten when a transfer completes
      rsp_q.rdata <= '0;
      rsp_q.err   <= 1'b1;
    end else if (state_q == soc_periph_pkg::st_access && sel_rsp.pready) begin
      rsp_q.rdata <= sel_rsp.prdata;
      rsp_q.err   <= sel_rsp.pslverr;
    end
  end

  assign rsp_valid_o = (state_q == soc_periph_pkg::st_respond);
  assign rsp_o       = rsp_q;

  assign apb_o.paddr   = req_q.addr;
  assign apb_o.pwdata  = req_q.wdata;
  assign apb_o.pstrb   = req_q.strb;
  assign apb_o.pwrite  = req_q.write;
  assign apb_o.penable = (state_q == soc_periph_pkg::st_access);

  assign apb_sel_o = (state_q == soc_periph_pkg::st_setup ||
                      state_q == soc_periph_pkg::st_access) ? sel_q : '0;

  a_sel_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(apb_sel_o));

  a_enable_selected: assert property (@(posedge clk_i) disable iff (reset_i)
    apb_o.penable |-> (apb_sel_o != '0));

  // Setup is always followed by an access to the same slave with the same payload
  a_setup_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_q == soc_periph_pkg::st_setup) |=>
      apb_o.penable && $stable(apb_sel_o) && $stable(apb_o.paddr) &&
      $stable(apb_o.pwdata) && $stable(apb_o.pstrb) && $stable(apb_o.pwrite));

endmodule

/* logic/soc_ctrl_regs.sv */
// SoC control registers
`timescale 1ns/10ps
`include "soc_periph_defs.svh"

module soc_ctrl_regs (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  soc_periph_pkg::apb_req_t   apb_i,
  input  logic                       psel_i,
  output soc_periph_pkg::apb_rsp_t   apb_rsp_o,
  output logic                       eoc_o,
  output logic [`SOC_DATA_WIDTH-1:0] exit_code_o
);

  localparam int unsigned word_lsb  = $clog2(`SOC_STRB_WIDTH);
  localparam int unsigned win_msb   = $clog2(`SOC_WINDOW_SIZE) - 1;
  localparam int unsigned idx_width = win_msb - word_lsb + 1;
  localparam int unsigned sel_width = $bits(soc_periph_pkg::ctrl_reg_e);

  logic [idx_width-1:0]       word_idx;
  soc_periph_pkg::ctrl_reg_e  reg_sel;
  logic                       idx_ok;
  logic                       bad_access;
  logic                       wr_en;
  logic [`SOC_DATA_WIDTH-1:0] scratch0_q;
  logic [`SOC_DATA_WIDTH-1:0] scratch1_q;
  logic [`SOC_DATA_WIDTH-1:0] exit_code_q;
  logic                       eoc_q;

  // Replace only the bytes whose strobe is set
  function automatic logic [`SOC_DATA_WIDTH-1:0] strb_merge(
    input logic [`SOC_DATA_WIDTH-1:0] old_val,
    input logic [`SOC_DATA_WIDTH-1:0] new_val,
    input logic [`SOC_STRB_WIDTH-1:0] strb
  );
    logic [`SOC_DATA_WIDTH-1:0] res;
    res = old_val;
    for (int b = 0; b < `SOC_STRB_WIDTH; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign word_idx = apb_i.paddr[win_msb:word_lsb];
  assign idx_ok   = (word_idx <= idx_width'(soc_periph_pkg::reg_exit_code));
  assign reg_sel  = soc_periph_pkg::ctrl_reg_e'(word_idx[sel_width-1:0]);

  // Info is read-only and everything past exit_code is unmapped
  assign bad_access = !idx_ok || (apb_i.pwrite && reg_sel == soc_periph_pkg::reg_info);
  assign wr_en      = psel_i && apb_i.penable && apb_i.pwrite && !bad_access;

  // Zero wait states, the response is ready in the access cycle
  always_comb begin
    apb_rsp_o         = '0;
    apb_rsp_o.pready  = psel_i && apb_i.penable;
    apb_rsp_o.pslverr = psel_i && bad_access;
    if (idx_ok) begin
      case (reg_sel)
        soc_periph_pkg::reg_info:
          apb_rsp_o.prdata = {16'(`SOC_N_CLUSTERS), 16'(`SOC_N_CORES)};
        soc_periph_pkg::reg_scratch0:  apb_rsp_o.prdata = scratch0_q;
        soc_periph_pkg::reg_scratch1:  apb_rsp_o.prdata = scratch1_q;
        soc_periph_pkg::reg_eoc:       apb_rsp_o.prdata = `SOC_DATA_WIDTH'(eoc_q);
        soc_periph_pkg::reg_exit_code: apb_rsp_o.prdata = exit_code_q;
        default:                       apb_rsp_o.prdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      scratch0_q  <= '0;
      scratch1_q  <= '0;
      eoc_q       <= 1'b0;
      exit_code_q <= '0;
    end else if (wr_en) begin
      case (reg_sel)
        soc_periph_pkg::reg_scratch0:
          scratch0_q <= strb_merge(scratch0_q, apb_i.pwdata, apb_i.pstrb);
        soc_periph_pkg::reg_scratch1:
          scratch1_q <= strb_merge(scratch1_q, apb_i.pwdata, apb_i.pstrb);
        soc_periph_pkg::reg_eoc:       eoc_q       <= apb_i.pwdata[0];
        soc_periph_pkg::reg_exit_code: exit_code_q <= apb_i.pwdata;
        default: ;
      endcase
    end
  end

  assign eoc_o       = eoc_q;
  assign exit_code_o = exit_code_q;

  // Ready only comes in an access phase that directly follows its setup phase
  a_ready_after_setup: assert property (@(posedge clk_i) disable iff (reset_i)
    apb_rsp_o.pready |-> psel_i && $past(psel_i && !apb_i.penable));

endmodule

/* logic/soc_periph_defs.svh */
// SoC peripheral memory map and sizes
`ifndef SOC_PERIPH_DEFS_SVH
`define SOC_PERIPH_DEFS_SVH

// Bus widths of the host port and the APB side
`define SOC_ADDR_WIDTH 32
`define SOC_DATA_WIDTH 32
`define SOC_STRB_WIDTH (`SOC_DATA_WIDTH / 8)

// System size as reported by the info register
`define SOC_N_CORES    8
`define SOC_N_CLUSTERS 2

// Base of the peripheral region in the host address space
`define SOC_PERIPH_BASE 32'h1A10_0000

// Window offsets from the peripheral base, each window is 4 KiB
`define SOC_CTRL_OFFSET   32'h0000_3000
`define SOC_STDOUT_OFFSET 32'h0000_4000
`define SOC_WINDOW_SIZE   32'h0000_1000

// One select line per APB peripheral
`define SOC_N_APB_SLAVES 2

// Width of each per-core character counter
`define SOC_COUNT_WIDTH 16

`endif

/* logic/soc_periph_pkg.sv */
// SoC peripheral bus types
`include "soc_periph_defs.svh"

package soc_periph_pkg;

  // Single-beat host request, captured by the bridge on accept
  typedef struct packed {
    logic [`SOC_ADDR_WIDTH-1:0] addr;
    logic [`SOC_DATA_WIDTH-1:0] wdata;
    logic [`SOC_STRB_WIDTH-1:0] strb;
    logic                       write;
  } host_req_t;

  // Host response, valid for one cycle only
  typedef struct packed {
    logic [`SOC_DATA_WIDTH-1:0] rdata;
    logic                       err;
  } host_rsp_t;

  // Shared APB request, the select lines travel on their own
  typedef struct packed {
    logic [`SOC_ADDR_WIDTH-1:0] paddr;
    logic [`SOC_DATA_WIDTH-1:0] pwdata;
    logic [`SOC_STRB_WIDTH-1:0] pstrb;
    logic                       pwrite;
    logic                       penable;
  } apb_req_t;

  typedef struct packed {
    logic [`SOC_DATA_WIDTH-1:0] prdata;
    logic                       pready;
    logic                       pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_access,
    st_respond
  } bridge_state_e;

  // Word index inside the control window
  typedef enum logic [2:0] {
    reg_info      = 3'd0,
    reg_scratch0  = 3'd1,
    reg_scratch1  = 3'd2,
    reg_eoc       = 3'd3,
    reg_exit_code = 3'd4
  } ctrl_reg_e;

  // One character written by one core
  typedef struct packed {
    logic [$clog2(`SOC_N_CORES)-1:0] core;
    logic [7:0]                      chr;
  } stdout_evt_t;

endpackage

/* logic/soc_peripherals.sv */
// SoC peripheral subsystem
`timescale 1ns/10ps
`include "soc_periph_defs.svh"

module soc_peripherals (
  input  logic                        clk_i,
  input  logic                        reset_i,

  // Host request and response port
  input  logic                        req_valid_i,
  input  soc_periph_pkg::host_req_t   req_i,
  output logic                        req_ready_o,
  output logic                        rsp_valid_o,
  output soc_periph_pkg::host_rsp_t   rsp_o,

  // End of computation status
  output logic                        eoc_o,
  output logic [`SOC_DATA_WIDTH-1:0]  exit_code_o,

  // Character stream
  output logic                        stdout_valid_o,
  output soc_periph_pkg::stdout_evt_t stdout_o
);

  soc_periph_pkg::apb_req_t                         apb_req;
  logic [`SOC_N_APB_SLAVES-1:0]                     apb_sel;
  soc_periph_pkg::apb_rsp_t [`SOC_N_APB_SLAVES-1:0] apb_rsp;

  soc_apb_bridge i_apb_bridge (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .apb_o       (apb_req),
    .apb_sel_o   (apb_sel),
    .apb_rsp_i   (apb_rsp)
  );

  // Slave 0 of the address map
  soc_ctrl_regs i_soc_ctrl_regs (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .apb_i       (apb_req),
    .psel_i      (apb_sel[0]),
    .apb_rsp_o   (apb_rsp[0]),
    .eoc_o       (eoc_o),
    .exit_code_o (exit_code_o)
  );

  // Slave 1 of the address map
  apb_stdout i_stdout (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .apb_i          (apb_req),
    .psel_i         (apb_sel[1]),
    .apb_rsp_o      (apb_rsp[1]),
    .stdout_valid_o (stdout_valid_o),
    .stdout_o       (stdout_o)
  );

endmodule

/* sim/tb_soc_peripherals.sv */
// Peripheral subsystem testbench
`timescale 1ns/10ps
`include "soc_periph_defs.svh"

module tb_soc_peripherals;

  localparam int n_scratch = 24;
  localparam int n_eoc     = 4;
  localparam int n_stdout  = 40;
  localparam int n_err     = 6;
  localparam int n_lat     = 6;
  localparam int rsp_limit = 16;
  localparam int n_words   = `SOC_WINDOW_SIZE / 4;
  // Transactions issued by all tests together, sizes the watchdog
  localparam int n_txn = 1 + 2 * n_scratch + 4 * n_eoc + n_stdout + `SOC_N_CORES +
                         4 * n_err + 4 + `SOC_N_CORES + 2 * n_lat;
  localparam int wd_cycles = n_txn * 10 + 50;
  localparam logic [31:0] ctrl_base   = `SOC_PERIPH_BASE + `SOC_CTRL_OFFSET;
  localparam logic [31:0] stdout_base = `SOC_PERIPH_BASE + `SOC_STDOUT_OFFSET;

  logic                        clk = 1'b0;
  logic                        reset;
  logic                        req_valid;
  soc_periph_pkg::host_req_t   req;
  logic                        req_ready;
  logic                        rsp_valid;
  soc_periph_pkg::host_rsp_t   rsp;
  logic                        eoc;
  logic [31:0]                 exit_code;
  logic                        stdout_valid;
  soc_periph_pkg::stdout_evt_t stdout_evt;

  // Reference model state
  logic [31:0] scratch_m [2];
  logic        eoc_m;
  logic [31:0] exit_m;
  logic [15:0] count_m [`SOC_N_CORES];

  soc_periph_pkg::stdout_evt_t evt_q [$];
  int    seed;
  int    errors;
  int    tests_run;
  int    tests_failed;
  int    test_err_start;
  string cur_test;

  soc_peripherals i_dut (
    .clk_i          (clk),
    .reset_i        (reset),
    .req_valid_i    (req_valid),
    .req_i          (req),
    .req_ready_o    (req_ready),
    .rsp_valid_o    (rsp_valid),
    .rsp_o          (rsp),
    .eoc_o          (eoc),
    .exit_code_o    (exit_code),
    .stdout_valid_o (stdout_valid),
    .stdout_o       (stdout_evt)
  );

  always #50 clk = ~clk;

  // Character strobes are collected here and consumed by the tests
  always @(negedge clk) begin
    if (!reset && stdout_valid) begin
      evt_q.push_back(stdout_evt);
    end
  end

  initial begin
    #(wd_cycles * 100);
    $display("Watchdog expired after %0d cycles, the tests did not complete", wd_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

  function automatic logic [31:0] byte_mask(input logic [3:0] strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

  function automatic logic in_window(input logic [31:0] addr);
    return ((addr - ctrl_base) < `SOC_WINDOW_SIZE) ||
           ((addr - stdout_base) < `SOC_WINDOW_SIZE);
  endfunction

  task check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("error: %s: %s expected 0x%08h actual 0x%08h", cur_test, what, exp, act);
    end
  endtask

  task start_test(input string name);
    cur_test       = name;
    test_err_start = errors;
  endtask

  task finish_test;
    tests_run++;
    if (errors > test_err_start) begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", cur_test, errors - test_err_start);
    end else begin
      $display("test %s: ok", cur_test);
    end
  endtask

  // One host transaction, lat counts cycles from accept to the response
  task run_txn(input logic [31:0] addr, input logic [31:0] wdata, input logic [3:0] strb,
               input logic wr, output logic [31:0] rdata, output logic err, output int lat);
    soc_periph_pkg::host_req_t r;
    logic                      got;
    r.addr  = addr;
    r.wdata = wdata;
    r.strb  = strb;
    r.write = wr;
    got     = 1'b0;
    rdata   = 'x;
    err     = 1'bx;
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= r;
    @(negedge clk);
    check_value("ready at request", 1, req_ready);
    @(posedge clk);
    req_valid <= 1'b0;
    lat = 0;
    while (!got && lat < rsp_limit) begin
      @(negedge clk);
      lat++;
      if (rsp_valid) begin
        got   = 1'b1;
        rdata = rsp.rdata;
        err   = rsp.err;
      end
    end
    if (!got) begin
      errors++;
      $display("%s: no response from the DUT within %0d cycles", cur_test, rsp_limit);
    end
    @(posedge clk);
  endtask

  task write_reg(input logic [31:0] addr, input logic [31:0] data, input logic [3:0] strb,
                 output logic err);
    logic [31:0] rd;
    int          lat;
    run_txn(addr, data, strb, 1'b1, rd, err, lat);
  endtask

  task read_reg(input logic [31:0] addr, output logic [31:0] data, output logic err);
    int lat;
    run_txn(addr, 32'h0, 4'h0, 1'b0, data, err, lat);
  endtask

  // Every register and counter must match the model
  task compare_state;
    logic [31:0] rd;
    logic        err;
    read_reg(ctrl_base + 4, rd, err);
    check_value("scratch0 readback", scratch_m[0], rd);
    read_reg(ctrl_base + 8, rd, err);
    check_value("scratch1 readback", scratch_m[1], rd);
    read_reg(ctrl_base + 12, rd, err);
    check_value("eoc readback", 32'(eoc_m), rd);
    read_reg(ctrl_base + 16, rd, err);
    check_value("exit code readback", exit_m, rd);
    check_value("eoc output", eoc_m, eoc);
    check_value("exit code output", exit_m, exit_code);
    for (int c = 0; c < `SOC_N_CORES; c++) begin
      read_reg(stdout_base + 32'(4 * c), rd, err);
      check_value("core count", 32'(count_m[c]), rd);
      check_value("count read error", 0, err);
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] data;
    logic [31:0] tmp;
    logic [31:0] addr;
    logic        err;
    int          idx;
    int          lat;
    soc_periph_pkg::stdout_evt_t ev;
    seed         = 7154;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    reset        = 1'b1;
    req_valid    = 1'b0;
    req          = '0;
    scratch_m    = '{default: '0};
    count_m      = '{default: '0};
    eoc_m        = 1'b0;
    exit_m       = '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);

    start_test("reset_info");
    check_value("ready after reset", 1, req_ready);
    check_value("eoc after reset", 0, eoc);
    check_value("exit code after reset", 0, exit_code);
    check_value("response valid after reset", 0, rsp_valid);
    check_value("stdout valid after reset", 0, stdout_valid);
    read_reg(ctrl_base, rd, err);
    check_value("info", (`SOC_N_CLUSTERS << 16) | `SOC_N_CORES, rd);
    check_value("info error", 0, err);
    finish_test;

    start_test("scratch");
    for (int i = 0; i < n_scratch; i++) begin
      tmp  = $random(seed);
      data = $random(seed);
      idx  = tmp[4];
      write_reg(ctrl_base + 32'(4 * (idx + 1)), data, tmp[3:0], err);
      check_value("scratch write error", 0, err);
      scratch_m[idx] = (scratch_m[idx] & ~byte_mask(tmp[3:0])) | (data & byte_mask(tmp[3:0]));
      read_reg(ctrl_base + 32'(4 * (idx + 1)), rd, err);
      check_value("scratch read", scratch_m[idx], rd);
    end
    finish_test;

    start_test("eoc");
    for (int i = 0; i < n_eoc; i++) begin
      data = $random(seed);
      // The last round always leaves end of computation set
      if (i == n_eoc - 1) begin
        data[0] = 1'b1;
      end
      write_reg(ctrl_base + 12, data, 4'hf, err);
      check_value("eoc write error", 0, err);
      eoc_m = data[0];
      data  = $random(seed);
      write_reg(ctrl_base + 16, data, 4'hf, err);
      check_value("exit code write error", 0, err);
      exit_m = data;
      check_value("eoc output", eoc_m, eoc);
      check_value("exit code output", exit_m, exit_code);
      read_reg(ctrl_base + 12, rd, err);
      check_value("eoc read", 32'(eoc_m), rd);
      read_reg(ctrl_base + 16, rd, err);
      check_value("exit code read", exit_m, rd);
    end
    finish_test;

    start_test("stdout");
    for (int i = 0; i < n_stdout; i++) begin
      idx  = $unsigned($random(seed)) % `SOC_N_CORES;
      data = $random(seed);
      write_reg(stdout_base + 32'(4 * idx), data, 4'hf, err);
      check_value("stdout write error", 0, err);
      check_value("events per write", 1, evt_q.size());
      if (evt_q.size() > 0) begin
        ev = evt_q.pop_front();
        check_value("event core", idx, ev.core);
        check_value("event character", data[7:0], ev.chr);
      end
      evt_q.delete();
      count_m[idx]++;
    end
    for (int c = 0; c < `SOC_N_CORES; c++) begin
      read_reg(stdout_base + 32'(4 * c), rd, err);
      check_value("core count", 32'(count_m[c]), rd);
    end
    finish_test;

    start_test("errors");
    for (int i = 0; i < n_err; i++) begin
      addr = $random(seed);
      while (in_window(addr)) begin
        addr = $random(seed);
      end
      tmp = $random(seed);
      run_txn(addr, $random(seed), 4'hf, tmp[0], rd, err, lat);
      check_value("unmapped error", 1, err);
      write_reg(ctrl_base, $random(seed), 4'hf, err);
      check_value("info write error", 1, err);
      idx = 5 + $unsigned($random(seed)) % (n_words - 5);
      run_txn(ctrl_base + 32'(4 * idx), $random(seed), 4'hf, tmp[1], rd, err, lat);
      check_value("control offset error", 1, err);
      idx = `SOC_N_CORES + $unsigned($random(seed)) % (n_words - `SOC_N_CORES);
      run_txn(stdout_base + 32'(4 * idx), $random(seed), 4'hf, tmp[2], rd, err, lat);
      check_value("stdout offset error", 1, err);
    end
    check_value("events from errors", 0, evt_q.size());
    compare_state;
    finish_test;

    start_test("latency");
    for (int i = 0; i < n_lat; i++) begin
      addr = (i % 2 == 0) ? ctrl_base + 32'(4 * (i % 5)) : stdout_base + 32'(4 * i);
      run_txn(addr, 32'h0, 4'h0, 1'b0, rd, err, lat);
      check_value("hit latency", 3, lat);
      addr = $random(seed);
      while (in_window(addr)) begin
        addr = $random(seed);
      end
      run_txn(addr, 32'h0, 4'h0, 1'b0, rd, err, lat);
      check_value("miss latency", 1, lat);
    end
    finish_test;

    $display("tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
             errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
